/* rtl/rob_pkg.sv */
package rob_pkg;

    localparam int ROB_SIZE  = 16;
    localparam int ROB_IDX_W = 4;   // log2 of ROB_SIZE
    localparam int NUM_WB    = 3;   // writeback ports
    localparam int PC_W      = 32;
    localparam int LREG_W    = 5;
    localparam int PREG_W    = 6;

    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [LREG_W-1:0]    lreg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // msb is the wrap flag, low bits index the slot
    typedef logic [ROB_IDX_W:0]   rob_id_t;

    // holds 0 up to ROB_SIZE
    typedef logic [ROB_IDX_W:0]   rob_cnt_t;

    // what dispatch leaves in an entry
    typedef struct packed {
        pc_t   pc;
        lreg_t lrd;
        preg_t prd;
        preg_t old_prd;      // freed on commit
        logic  need_to_wb;   // updates the arch rat on commit
    } rob_payload_t;

    typedef struct packed {
        logic    valid;
        rob_id_t robid;
    } rob_wb_t;

    typedef struct packed {
        logic         valid;
        rob_id_t      robid;   // store queue wakeup
        rob_payload_t payload;
    } rob_commit_t;

    // one rollback cycle per flush
    typedef enum logic [0:0] {
        ROB_IDLE     = 1'b0,
        ROB_ROLLBACK = 1'b1
    } rob_state_e;

endpackage

/* rtl/rob_entry.sv */
`timescale 1ns/1ns

module rob_entry (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  write,
    input  rob_pkg::rob_payload_t write_data,
    input  logic                  set_complete,
    input  logic                  retire,
    input  logic                  kill,
    output logic                  valid,
    output logic                  complete,
    output rob_pkg::rob_payload_t data
);

    // slot state
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid    <= 1'b0;
            complete <= 1'b0;
        end else if (write) begin
            valid    <= 1'b1;
            complete <= 1'b0;   // fresh instruction, not executed yet
        end else if (retire || kill) begin
            valid    <= 1'b0;
            complete <= 1'b0;
        end else if (set_complete) begin
            complete <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            data <= write_data;
        end
    end

endmodule

/* rtl/rob_entry_array.sv */
`timescale 1ns/1ns

module rob_entry_array (
    input  logic                                   clock,
    input  logic                                   reset_n,
    input  logic                                   enq0_valid,
    input  logic                                   enq1_valid,
    input  rob_pkg::rob_payload_t                  enq0_data,
    input  rob_pkg::rob_payload_t                  enq1_data,
    input  rob_pkg::rob_id_t                       enq_ptr,
    input  rob_pkg::rob_id_t                       deq_ptr,
    input  rob_pkg::rob_wb_t [rob_pkg::NUM_WB-1:0] wb,
    input  logic                                   rollback,
    input  rob_pkg::rob_id_t                       flush_robid,
    output logic                                   head_commit,
    output rob_pkg::rob_payload_t                  head_data
);

    rob_pkg::rob_idx_t            enq0_idx;
    rob_pkg::rob_idx_t            enq1_idx;
    rob_pkg::rob_idx_t            head_idx;
    rob_pkg::rob_id_t             keep_next;   // oldest robid to throw away
    rob_pkg::rob_cnt_t            kill_cnt;
    logic [rob_pkg::ROB_SIZE-1:0] slot_valid;
    logic [rob_pkg::ROB_SIZE-1:0] slot_complete;
    rob_pkg::rob_payload_t        slot_data [rob_pkg::ROB_SIZE];

    assign enq0_idx  = enq_ptr[rob_pkg::ROB_IDX_W-1:0];
    assign enq1_idx  = enq0_idx + 1'b1;   // wraps with the slot index
    assign head_idx  = deq_ptr[rob_pkg::ROB_IDX_W-1:0];
    assign keep_next = flush_robid + 1'b1;

    // number of wrong-path entries between the kept one and the tail
    assign kill_cnt = rob_pkg::rob_cnt_t'(enq_ptr - keep_next);

    assign head_commit = slot_valid[head_idx] & slot_complete[head_idx];
    assign head_data   = slot_data[head_idx];

    for (genvar i = 0; i < rob_pkg::ROB_SIZE; i++) begin : g_slot
        logic              hit0;
        logic              hit1;
        logic              wb_hit;
        logic              retire;
        logic              kill;
        rob_pkg::rob_idx_t kill_ofs;   // distance past the kept entry

        assign hit0   = enq0_valid & (enq0_idx == rob_pkg::rob_idx_t'(i));
        assign hit1   = enq1_valid & (enq1_idx == rob_pkg::rob_idx_t'(i));
        assign retire = head_commit & (head_idx == rob_pkg::rob_idx_t'(i));

        assign kill_ofs = rob_pkg::rob_idx_t'(i) - keep_next[rob_pkg::ROB_IDX_W-1:0];
        assign kill     = rollback & (rob_pkg::rob_cnt_t'(kill_ofs) < kill_cnt);

        // any of the wb ports may hit this slot
        always_comb begin
            wb_hit = 1'b0;
            for (int p = 0; p < rob_pkg::NUM_WB; p++) begin
                if (wb[p].valid &&
                    wb[p].robid[rob_pkg::ROB_IDX_W-1:0] == rob_pkg::rob_idx_t'(i)) begin
                    wb_hit = 1'b1;
                end
            end
        end

        rob_entry u_entry (
            .clock        (clock),
            .reset_n      (reset_n),
            .write        (hit0 | hit1),
            .write_data   (hit1 ? enq1_data : enq0_data),
            .set_complete (wb_hit),
            .retire       (retire),
            .kill         (kill),
            .valid        (slot_valid[i]),
            .complete     (slot_complete[i]),
            .data         (slot_data[i])
        );
    end

endmodule

/* rtl/rob_queue_ctrl.sv */
`timescale 1ns/1ns

module rob_queue_ctrl (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                enq0_valid,
    input  logic                enq1_valid,
    input  logic                head_commit,
    input  logic                flush_valid,
    input  rob_pkg::rob_id_t    flush_robid,
    output rob_pkg::rob_id_t    enq_ptr,
    output rob_pkg::rob_id_t    deq_ptr,
    output logic                rollback,
    output logic                can_enq,
    output rob_pkg::rob_state_e rob_state
);

    rob_pkg::rob_state_e state_next;
    rob_pkg::rob_cnt_t   count;     // live entries
    rob_pkg::rob_cnt_t   enq_num;
    rob_pkg::rob_id_t    deq_next;
    rob_pkg::rob_id_t    keep_next;

    assign enq_num   = rob_pkg::rob_cnt_t'(enq0_valid) + rob_pkg::rob_cnt_t'(enq1_valid);
    assign deq_next  = deq_ptr + rob_pkg::rob_id_t'(head_commit);
    assign keep_next = flush_robid + 1'b1;

    assign rollback = (rob_state == rob_pkg::ROB_ROLLBACK);

    // room for a full pair, nothing while a flush is pending
    assign can_enq = (rob_state == rob_pkg::ROB_IDLE) && !flush_valid &&
                     (count <= rob_pkg::rob_cnt_t'(rob_pkg::ROB_SIZE - 2));

    always_comb begin
        state_next = rob_state;
        case (rob_state)
            rob_pkg::ROB_IDLE: begin
                if (flush_valid) begin
                    state_next = rob_pkg::ROB_ROLLBACK;
                end
            end
            rob_pkg::ROB_ROLLBACK: begin
                if (!flush_valid) begin
                    state_next = rob_pkg::ROB_IDLE;   // a new flush stays here
                end
            end
            default: begin
                state_next = rob_pkg::ROB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rob_state <= rob_pkg::ROB_IDLE;
        end else begin
            rob_state <= state_next;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            count   <= '0;
        end else begin
            deq_ptr <= deq_next;   // one retire per cycle at most
            if (rollback) begin
                // tail lands right behind the kept entry
                enq_ptr <= keep_next;
                count   <= rob_pkg::rob_cnt_t'(keep_next - deq_next);
            end else begin
                enq_ptr <= enq_ptr + rob_pkg::rob_id_t'(enq_num);
                count   <= count + enq_num - rob_pkg::rob_cnt_t'(head_commit);
            end
        end
    end

endmodule

/* rtl/rob.sv */
`timescale 1ns/1ns

module rob (
    input  logic                                   clock,
    input  logic                                   reset_n,
    input  logic                                   enq0_valid,
    input  logic                                   enq1_valid,
    input  rob_pkg::rob_payload_t                  enq0_data,
    input  rob_pkg::rob_payload_t                  enq1_data,
    output rob_pkg::rob_id_t                       enq_robid,   // robid of enq0
    output logic                                   can_enq,
    input  rob_pkg::rob_wb_t [rob_pkg::NUM_WB-1:0] wb,
    output rob_pkg::rob_commit_t                   commit,
    input  logic                                   flush_valid,
    input  rob_pkg::rob_id_t                       flush_robid, // last robid kept
    output rob_pkg::rob_state_e                    rob_state
);

    rob_pkg::rob_id_t      enq_ptr;
    rob_pkg::rob_id_t      deq_ptr;
    logic                  rollback;
    logic                  head_commit;
    rob_pkg::rob_payload_t head_data;

    rob_queue_ctrl u_ctrl (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq0_valid  (enq0_valid),
        .enq1_valid  (enq1_valid),
        .head_commit (head_commit),
        .flush_valid (flush_valid),
        .flush_robid (flush_robid),
        .enq_ptr     (enq_ptr),
        .deq_ptr     (deq_ptr),
        .rollback    (rollback),
        .can_enq     (can_enq),
        .rob_state   (rob_state)
    );

    rob_entry_array u_array (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq0_valid  (enq0_valid),
        .enq1_valid  (enq1_valid),
        .enq0_data   (enq0_data),
        .enq1_data   (enq1_data),
        .enq_ptr     (enq_ptr),
        .deq_ptr     (deq_ptr),
        .wb          (wb),
        .rollback    (rollback),
        .flush_robid (flush_robid),
        .head_commit (head_commit),
        .head_data   (head_data)
    );

    assign enq_robid = enq_ptr;

    // head entry goes out as is, consumer cannot stall it
    assign commit.valid   = head_commit;
    assign commit.robid   = deq_ptr;
    assign commit.payload = head_data;

endmodule

/* dv/rob_tb.sv */
`timescale 1ns/1ns

module rob_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int CYCLE_BUDGET = 400;   // all five tests together

    typedef struct packed {
        rob_pkg::rob_id_t      robid;
        rob_pkg::rob_payload_t payload;
    } ref_entry_t;

    logic                                   clock;
    logic                                   reset_n;
    logic                                   enq0_valid;
    logic                                   enq1_valid;
    rob_pkg::rob_payload_t                  enq0_data;
    rob_pkg::rob_payload_t                  enq1_data;
    rob_pkg::rob_id_t                       enq_robid;
    logic                                   can_enq;
    rob_pkg::rob_wb_t [rob_pkg::NUM_WB-1:0] wb;
    rob_pkg::rob_commit_t                   commit;
    logic                                   flush_valid;
    rob_pkg::rob_id_t                       flush_robid;
    rob_pkg::rob_state_e                    rob_state;

    integer           seed = 32'h8f30;
    int               errors;
    int               tests_run;
    int               commits;
    int               errors_at_start;
    ref_entry_t       ref_q [$];     // program order
    rob_pkg::rob_id_t pending [$];   // accepted, not yet written back
    rob_pkg::rob_id_t tail_robid;    // expected enq_robid
    rob_pkg::rob_id_t head_robid;    // robid due to retire next
    ref_entry_t       exp_head;      // what the shown commit should be
    logic             exp_ok;
    logic             head_wb;

    rob u_rob (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq0_valid  (enq0_valid),
        .enq1_valid  (enq1_valid),
        .enq0_data   (enq0_data),
        .enq1_data   (enq1_data),
        .enq_robid   (enq_robid),
        .can_enq     (can_enq),
        .wb          (wb),
        .commit      (commit),
        .flush_valid (flush_valid),
        .flush_robid (flush_robid),
        .rob_state   (rob_state)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // a writeback that hits the entry due to retire next
    always_comb begin
        head_wb = 1'b0;
        for (int p = 0; p < rob_pkg::NUM_WB; p++) begin
            if (wb[p].valid && wb[p].robid == head_robid && !commit.valid) begin
                head_wb = 1'b1;
            end
        end
    end

    // pop the reference entry for the commit shown this cycle
    always @(negedge clock) begin
        if (reset_n && commit.valid) begin
            commits++;
            exp_ok = (ref_q.size() > 0);
            if (exp_ok) begin
                exp_head   = ref_q.pop_front();
                head_robid = exp_head.robid + 1'b1;
            end
        end
    end

    a_commit_robid: assert property (@(posedge clock) disable iff (!reset_n)
        commit.valid |-> exp_ok && commit.robid == exp_head.robid)
        else begin
            $display("Fail %0t: commit robid %0d, expected %0d", $time,
                     $sampled(commit.robid), $sampled(exp_head.robid));
            errors++;
        end

    a_commit_payload: assert property (@(posedge clock) disable iff (!reset_n)
        commit.valid |-> commit.payload == exp_head.payload)
        else begin
            $display("Fail %0t: commit payload of robid %0d differs from the one sent",
                     $time, $sampled(commit.robid));
            errors++;
        end

    a_tail: assert property (@(posedge clock) disable iff (!reset_n)
        rob_state == rob_pkg::ROB_IDLE |-> enq_robid == tail_robid)
        else begin
            $display("Fail %0t: enq_robid %0d, expected %0d", $time,
                     $sampled(enq_robid), $sampled(tail_robid));
            errors++;
        end

    a_flush_block: assert property (@(posedge clock) disable iff (!reset_n)
        (flush_valid || rob_state == rob_pkg::ROB_ROLLBACK) |-> !can_enq)
        else begin
            $display("Fail %0t: can_enq high during flush or rollback", $time);
            errors++;
        end

    a_rb_enter: assert property (@(posedge clock) disable iff (!reset_n)
        flush_valid && rob_state == rob_pkg::ROB_IDLE |=> rob_state == rob_pkg::ROB_ROLLBACK)
        else begin
            $display("Fail %0t: flush did not start a rollback", $time);
            errors++;
        end

    a_rb_leave: assert property (@(posedge clock) disable iff (!reset_n)
        rob_state == rob_pkg::ROB_ROLLBACK && !flush_valid |=> rob_state == rob_pkg::ROB_IDLE)
        else begin
            $display("Fail %0t: rollback lasted more than one cycle", $time);
            errors++;
        end

    a_wb_head: assert property (@(posedge clock) disable iff (!reset_n)
        head_wb |=> commit.valid)
        else begin
            $display("Fail %0t: head written back but commit.valid stayed low", $time);
            errors++;
        end

    a_enq_legal: assert property (@(posedge clock) disable iff (!reset_n)
        (enq0_valid || enq1_valid) |-> can_enq && enq0_valid)
        else begin
            $display("Dispatch drove an instruction at %0t that the ROB could not take", $time);
            errors++;
        end

    function automatic rob_pkg::rob_payload_t random_payload();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[$bits(rob_pkg::rob_payload_t)-1:0];
    endfunction

    task automatic verify(input bit cond, input string what);
        assert (cond) else begin
            $display("Fail %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
                 (errors == errors_at_start) ? "ok" : "failed");
        errors_at_start = errors;
    endtask

    // one or two instructions, taken on the edge after they are driven
    task automatic enqueue(input int n);
        ref_entry_t e0;
        ref_entry_t e1;
        @(negedge clock);
        while (!can_enq) begin
            @(negedge clock);
        end
        e0.robid   = tail_robid;
        e0.payload = random_payload();
        e1.robid   = tail_robid + 1'b1;
        e1.payload = random_payload();
        @(posedge clock);
        enq0_valid <= 1'b1;
        enq1_valid <= (n == 2);
        enq0_data  <= e0.payload;
        enq1_data  <= e1.payload;
        ref_q.push_back(e0);
        pending.push_back(e0.robid);
        if (n == 2) begin
            ref_q.push_back(e1);
            pending.push_back(e1.robid);
        end
        @(posedge clock);   // accepted here
        enq0_valid <= 1'b0;
        enq1_valid <= 1'b0;
        tail_robid <= tail_robid + rob_pkg::rob_id_t'(n);
    endtask

    // shuffled writebacks that use all ports per cycle when burst is set
    task automatic write_back_all(input bit burst);
        rob_pkg::rob_id_t ids [$];
        rob_pkg::rob_id_t tmp;
        int               j;
        int               k;
        ids = pending;
        pending.delete();
        for (int i = ids.size() - 1; i > 0; i--) begin
            j      = $unsigned($random(seed)) % (i + 1);
            tmp    = ids[i];
            ids[i] = ids[j];
            ids[j] = tmp;
        end
        while (ids.size() > 0) begin
            k = burst ? rob_pkg::NUM_WB : 1 + $unsigned($random(seed)) % rob_pkg::NUM_WB;
            @(posedge clock);
            for (int p = 0; p < rob_pkg::NUM_WB; p++) begin
                if (p < k && ids.size() > 0) begin
                    tmp = ids.pop_front();
                    wb[p] <= {1'b1, tmp};
                end else begin
                    wb[p] <= '0;
                end
            end
        end
        @(posedge clock);
        wb <= '0;
    endtask

    task automatic wait_drained();
        while (ref_q.size() != 0) begin
            @(posedge clock);
        end
    endtask

    initial begin
        rob_pkg::rob_id_t keep_id;
        logic             start_wrap;
        int               sent;
        int               n;
        int               commits_before;
        clock           = 1'b0;
        reset_n         = 1'b0;
        enq0_valid      = 1'b0;
        enq1_valid      = 1'b0;
        enq0_data       = '0;
        enq1_data       = '0;
        wb              = '0;
        flush_valid     = 1'b0;
        flush_robid     = '0;
        tail_robid      = '0;
        head_robid      = '0;
        exp_head        = '0;
        exp_ok          = 1'b0;
        errors          = 0;
        tests_run       = 0;
        commits         = 0;
        errors_at_start = 0;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;

        @(negedge clock);
        verify(can_enq, "can_enq low after reset");
        verify(!commit.valid, "commit.valid high after reset");
        verify(enq_robid == '0, "enq_robid not zero after reset");
        verify(rob_state == rob_pkg::ROB_IDLE, "rob_state not idle after reset");
        report_test("reset");

        sent = 0;
        while (sent < 12) begin
            n = (sent < 11 && ($random(seed) & 1)) ? 2 : 1;
            enqueue(n);
            sent += n;
        end
        write_back_all(1'b0);
        wait_drained();
        verify(commits == 12, "ordering test committed a wrong number of entries");
        report_test("ordering");

        start_wrap = tail_robid[rob_pkg::ROB_IDX_W];
        repeat (7) enqueue(2);
        enqueue(1);   // 15 live now
        @(negedge clock);
        verify(!can_enq, "can_enq high with 15 entries live");
        verify(enq_robid[rob_pkg::ROB_IDX_W] != start_wrap, "wrap flag did not toggle");
        write_back_all(1'b0);
        wait_drained();
        @(negedge clock);
        verify(can_enq, "can_enq low after draining");
        report_test("full and wrap");

        enqueue(2);
        enqueue(1);
        write_back_all(1'b1);
        for (int c = 0; c < 3; c++) begin
            @(negedge clock);
            verify(commit.valid, "burst writeback did not commit on consecutive cycles");
        end
        @(negedge clock);
        verify(!commit.valid, "commit.valid high with an empty ROB");
        report_test("writeback ports");

        commits_before = commits;
        keep_id = tail_robid + 2'd2;   // third of the eight
        repeat (4) enqueue(2);
        @(posedge clock);
        flush_valid <= 1'b1;
        flush_robid <= keep_id;
        while (ref_q[$].robid != keep_id) begin
            void'(ref_q.pop_back());
            void'(pending.pop_back());
        end
        @(negedge clock);
        verify(!can_enq, "can_enq high with flush_valid set");
        @(posedge clock);
        flush_valid <= 1'b0;
        @(negedge clock);
        verify(rob_state == rob_pkg::ROB_ROLLBACK, "no rollback after flush");
        @(posedge clock);
        tail_robid <= keep_id + 1'b1;   // tail lands behind the kept entry
        @(negedge clock);
        verify(rob_state == rob_pkg::ROB_IDLE, "rob_state not idle after rollback");
        verify(enq_robid == keep_id + 1'b1, "enq_robid not flush_robid+1 after rollback");
        enqueue(2);
        write_back_all(1'b0);
        wait_drained();
        verify(commits == commits_before + 5, "flush test committed a wrong number of entries");
        report_test("flush");

        repeat (2) @(posedge clock);
        $display("%0d tests run, %0d commits, %0d failed checks", tests_run, commits, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // five times the summed test budget
    initial begin
        #(5 * CLK_PERIOD * CYCLE_BUDGET);
        $display("Run timed out after %0d cycles", 5 * CYCLE_BUDGET);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* files.f */
rtl/rob_pkg.sv
rtl/rob_entry.sv
rtl/rob_entry_array.sv
rtl/rob_queue_ctrl.sv
rtl/rob.sv
dv/rob_tb.sv

/* Bender.yml */
package:
  name: rob

sources:
  - rtl/rob_pkg.sv
  - rtl/rob_entry.sv
  - rtl/rob_entry_array.sv
  - rtl/rob_queue_ctrl.sv
  - rtl/rob.sv
  - target: test
    files:
      - dv/rob_tb.sv
